// File: logic/usb_txn_pkg.sv
package usb_txn_pkg;

  // Widths that carry a meaning on the USB side
  typedef logic [6:0] usb_addr_t;
  typedef logic [3:0] usb_endp_t;
  typedef logic [1:0] tok_type_t;
  typedef logic [1:0] hsk_type_t;
  typedef logic [7:0] usb_byte_t;
  typedef logic [15:0] word16_t;

  // Register bus widths
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0] axi_addr_t;

  // Token codes from the packet decoder
  // Code 01 is never turned into a transaction
  localparam tok_type_t TOK_OUT = 2'b00;
  localparam tok_type_t TOK_IN = 2'b10;
  localparam tok_type_t TOK_SETUP = 2'b11;

  // Handshake codes to the packet encoder
  localparam hsk_type_t HSK_ACK = 2'b00;
  localparam hsk_type_t HSK_NAK = 2'b10;
  localparam hsk_type_t HSK_STALL = 2'b11;

  // Register byte offsets
  localparam axi_addr_t REG_ADDR = 4'h0;
  localparam axi_addr_t REG_EPCTL = 4'h4;
  localparam axi_addr_t REG_STAT = 4'h8;

endpackage

// File: logic/usb_cfg_regs.sv
module usb_cfg_regs (
  input  logic                   clock,
  input  logic                   reset,
  input  usb_txn_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,
  input  usb_txn_pkg::axi_data_t s_axi_wdata_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,
  input  usb_txn_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,
  output usb_txn_pkg::axi_data_t s_axi_rdata_o,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i,
  input  logic                   setup_event_i,
  input  logic                   bulk_ack_event_i,
  output usb_txn_pkg::usb_addr_t dev_addr_o,
  output logic [1:0]             ep_enable_o,
  output logic [1:0]             ep_halt_o
);
  import usb_txn_pkg::*;

  logic wr_en;
  logic rd_en;
  logic [7:0] setup_cnt_q;
  logic [7:0] bulk_cnt_q;

  // AW and W are taken together, once no response is pending
  assign wr_en = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
  assign s_axi_awready_o = wr_en;
  assign s_axi_wready_o = wr_en;

  // One read in flight at a time
  assign s_axi_arready_o = !s_axi_rvalid_o;
  assign rd_en = s_axi_arvalid_i && s_axi_arready_o;

  // Write side and write response
  always_ff @(posedge clock) begin
    if (reset) begin
      dev_addr_o <= '0;
      ep_enable_o <= 2'b00;
      ep_halt_o <= 2'b00;
      s_axi_bvalid_o <= 1'b0;
    end else begin
      if (wr_en) begin
        s_axi_bvalid_o <= 1'b1;
        case (s_axi_awaddr_i)
          REG_ADDR: dev_addr_o <= s_axi_wdata_i[6:0];
          REG_EPCTL: begin
            ep_enable_o <= s_axi_wdata_i[1:0];
            ep_halt_o <= s_axi_wdata_i[5:4];
          end
          default: ;
        endcase
      end else if (s_axi_bready_i) begin
        s_axi_bvalid_o <= 1'b0;
      end
    end
  end

  // Event counters wrap; any write to REG_STAT clears both
  always_ff @(posedge clock) begin
    if (reset || (wr_en && s_axi_awaddr_i == REG_STAT)) begin
      setup_cnt_q <= '0;
      bulk_cnt_q <= '0;
    end else begin
      if (setup_event_i) setup_cnt_q <= setup_cnt_q + 8'd1;
      if (bulk_ack_event_i) bulk_cnt_q <= bulk_cnt_q + 8'd1;
    end
  end

  // Read data is registered, so rvalid follows arvalid by one cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      s_axi_rvalid_o <= 1'b0;
    end else if (rd_en) begin
      s_axi_rvalid_o <= 1'b1;
    end else if (s_axi_rready_i) begin
      s_axi_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_en) begin
      case (s_axi_araddr_i)
        REG_ADDR: s_axi_rdata_o <= {25'd0, dev_addr_o};
        REG_EPCTL: s_axi_rdata_o <= {26'd0, ep_halt_o, 2'b00, ep_enable_o};
        REG_STAT: s_axi_rdata_o <= {16'd0, bulk_cnt_q, setup_cnt_q};
        default: s_axi_rdata_o <= '0;
      endcase
    end
  end

endmodule

// File: logic/setup_parser.sv
module setup_parser (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   setup_active_i,
  input  logic                   out_tvalid_i,
  input  logic                   out_tready_i,
  input  logic                   out_tlast_i,
  input  logic [1:0]             out_ttype_i,
  input  usb_txn_pkg::usb_byte_t out_tdata_i,
  output usb_txn_pkg::usb_byte_t ctl_rtype_o,
  output usb_txn_pkg::usb_byte_t ctl_request_o,
  output usb_txn_pkg::word16_t   ctl_value_o,
  output usb_txn_pkg::word16_t   ctl_index_o,
  output usb_txn_pkg::word16_t   ctl_length_o,
  output logic                   setup_ok_o
);
  import usb_txn_pkg::*;

  // Bit 3 set means the packet already ran past eight bytes
  logic [3:0] byte_cnt_q;
  logic accept;

  assign accept = setup_active_i && out_tvalid_i && out_tready_i;

  // Well formed: last byte lands on index 7 of a DATA0 packet
  assign setup_ok_o = accept && out_tlast_i && byte_cnt_q == 4'd7 && !out_ttype_i[0];

  // Byte counter, saturating at 8 so long packets never look valid
  always_ff @(posedge clock) begin
    if (reset || !setup_active_i) begin
      byte_cnt_q <= '0;
    end else if (accept && !byte_cnt_q[3]) begin
      byte_cnt_q <= byte_cnt_q + 4'd1;
    end
  end

  // Request fields, little endian per the setup packet layout
  always_ff @(posedge clock) begin
    if (accept && !byte_cnt_q[3]) begin
      case (byte_cnt_q[2:0])
        3'd0: ctl_rtype_o <= out_tdata_i;
        3'd1: ctl_request_o <= out_tdata_i;
        3'd2: ctl_value_o[7:0] <= out_tdata_i;
        3'd3: ctl_value_o[15:8] <= out_tdata_i;
        3'd4: ctl_index_o[7:0] <= out_tdata_i;
        3'd5: ctl_index_o[15:8] <= out_tdata_i;
        3'd6: ctl_length_o[7:0] <= out_tdata_i;
        default: ctl_length_o[15:8] <= out_tdata_i;
      endcase
    end
  end

endmodule

// File: logic/bulk_out_endpoint.sv
module bulk_out_endpoint (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   bulk_active_i,
  input  logic                   discard_i,
  input  logic                   ep_sel_i,
  input  logic [1:0]             ep_enable_i,
  input  logic [1:0]             ep_halt_i,
  input  logic                   out_tvalid_i,
  input  logic                   out_tlast_i,
  input  logic [1:0]             out_ttype_i,
  input  usb_txn_pkg::usb_byte_t out_tdata_i,
  input  logic                   blk_tready_i,
  output logic                   out_tready_o,
  output logic                   blk_ep_o,
  output logic                   blk_tvalid_o,
  output logic                   blk_tlast_o,
  output usb_txn_pkg::usb_byte_t blk_tdata_o,
  output usb_txn_pkg::hsk_type_t bulk_hsk_type_o,
  output logic                   bulk_ack_o
);
  import usb_txn_pkg::*;

  // Expected DATA1 flag per endpoint, index 0 is ENDPOINT1
  logic [1:0] toggle_q;
  logic sel_halt;
  logic forward;
  logic accept;

  assign sel_halt = ep_halt_i[ep_sel_i];

  // Forward only a fresh packet to a running endpoint
  assign forward = bulk_active_i && !sel_halt && (out_ttype_i[0] == toggle_q[ep_sel_i]);

  // Forwarding follows the sink; discards and dumps drain at full rate
  assign out_tready_o = forward ? blk_tready_i : (discard_i || bulk_active_i);
  assign accept = out_tvalid_i && out_tready_o;

  // Stream passes straight through to the endpoint side
  assign blk_ep_o = ep_sel_i;
  assign blk_tvalid_o = forward && out_tvalid_i;
  assign blk_tlast_o = out_tlast_i;
  assign blk_tdata_o = out_tdata_i;

  // A halted endpoint stalls; duplicates are still acknowledged
  assign bulk_hsk_type_o = sel_halt ? HSK_STALL : HSK_ACK;
  assign bulk_ack_o = forward && accept && out_tlast_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      toggle_q <= 2'b00;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!ep_enable_i[i]) begin
          // Disabled endpoint restarts at DATA0
          toggle_q[i] <= 1'b0;
        end else if (bulk_ack_o && ep_sel_i == i[0]) begin
          toggle_q[i] <= ~toggle_q[i];
        end
      end
    end
  end

endmodule

// File: logic/handshake_issuer.sv
module handshake_issuer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   hsk_req_i,
  input  usb_txn_pkg::hsk_type_t hsk_req_type_i,
  input  logic                   hsk_sent_i,
  output logic                   hsk_send_o,
  output usb_txn_pkg::hsk_type_t hsk_type_o,
  output logic                   hsk_busy_o
);
  import usb_txn_pkg::*;

  // Request flag; held until the encoder confirms
  always_ff @(posedge clock) begin
    if (reset) begin
      hsk_send_o <= 1'b0;
    end else if (hsk_req_i && !hsk_send_o) begin
      hsk_send_o <= 1'b1;
    end else if (hsk_sent_i) begin
      hsk_send_o <= 1'b0;
    end
  end

  // Type is captured with the request and kept stable while pending
  always_ff @(posedge clock) begin
    if (hsk_req_i && !hsk_send_o) begin
      hsk_type_o <= hsk_req_type_i;
    end
  end

  // Busy clears in the confirming cycle, so the FSM leaves with the falling request
  assign hsk_busy_o = hsk_send_o && !hsk_sent_i;

endmodule

// File: logic/transaction_fsm.sv
module transaction_fsm #(
  parameter int ENDPOINT1 = 1,
  parameter int ENDPOINT2 = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   tok_recv_i,
  input  usb_txn_pkg::tok_type_t tok_type_i,
  input  usb_txn_pkg::usb_addr_t tok_addr_i,
  input  usb_txn_pkg::usb_endp_t tok_endp_i,
  input  usb_txn_pkg::usb_addr_t dev_addr_i,
  input  logic [1:0]             ep_enable_i,
  input  logic                   out_tvalid_i,
  input  logic                   out_tready_i,
  input  logic                   out_tlast_i,
  input  logic                   setup_ok_i,
  input  usb_txn_pkg::hsk_type_t bulk_hsk_type_i,
  input  logic                   bulk_ack_i,
  input  logic                   hsk_busy_i,
  output logic                   setup_active_o,
  output logic                   bulk_active_o,
  output logic                   ep_sel_o,
  output logic                   discard_o,
  output logic                   ctl_start_o,
  output logic                   hsk_req_o,
  output usb_txn_pkg::hsk_type_t hsk_req_type_o,
  output logic                   setup_event_o,
  output logic                   bulk_ack_event_o
);
  import usb_txn_pkg::*;

  typedef enum logic [2:0] {IDLE, SETUP_DATA, BULK_DATA, DUMP, HSK_WAIT} state_t;

  state_t state_q;
  state_t state_d;
  logic ep_sel_d;
  logic for_us;
  logic ep1_hit;
  logic ep2_hit;
  logic last_byte;
  logic start_q;
  logic bulk_event_q;

  // Token decode against our address and the enabled bulk endpoints
  assign for_us = tok_recv_i && tok_addr_i == dev_addr_i;
  assign ep1_hit = ep_enable_i[0] && tok_endp_i == usb_endp_t'(ENDPOINT1);
  assign ep2_hit = ep_enable_i[1] && tok_endp_i == usb_endp_t'(ENDPOINT2);

  // End of the data packet, as seen on the shared stream
  assign last_byte = out_tvalid_i && out_tready_i && out_tlast_i;

  always_comb begin
    state_d = state_q;
    ep_sel_d = ep_sel_o;
    hsk_req_o = 1'b0;
    hsk_req_type_o = HSK_ACK;
    case (state_q)
      IDLE: begin
        if (for_us && tok_type_i == TOK_SETUP && tok_endp_i == '0) begin
          state_d = SETUP_DATA;
        end else if (for_us && tok_type_i == TOK_OUT && (ep1_hit || ep2_hit)) begin
          state_d = BULK_DATA;
          ep_sel_d = ep2_hit;
        end else if (for_us && tok_type_i == TOK_IN && (ep1_hit || ep2_hit)) begin
          // No transmit path, so every bulk IN gets a NAK
          state_d = HSK_WAIT;
          hsk_req_o = 1'b1;
          hsk_req_type_o = HSK_NAK;
        end else if (tok_recv_i && (tok_type_i == TOK_OUT || tok_type_i == TOK_SETUP)) begin
          // Someone else's packet follows, drain it silently
          state_d = DUMP;
        end
      end
      SETUP_DATA: begin
        if (last_byte && setup_ok_i) begin
          state_d = HSK_WAIT;
          hsk_req_o = 1'b1;
        end else if (last_byte) begin
          // Malformed setup packet gets no handshake
          state_d = IDLE;
        end
      end
      BULK_DATA: begin
        if (last_byte) begin
          state_d = HSK_WAIT;
          hsk_req_o = 1'b1;
          hsk_req_type_o = bulk_hsk_type_i;
        end
      end
      DUMP: begin
        if (last_byte) state_d = IDLE;
      end
      HSK_WAIT: begin
        // Busy drops in the cycle the encoder confirms
        if (!hsk_busy_i) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= IDLE;
      ep_sel_o <= 1'b0;
      start_q <= 1'b0;
      bulk_event_q <= 1'b0;
    end else begin
      state_q <= state_d;
      ep_sel_o <= ep_sel_d;
      // Pulses line up with the rising handshake request
      start_q <= state_q == SETUP_DATA && last_byte && setup_ok_i;
      bulk_event_q <= state_q == BULK_DATA && bulk_ack_i;
    end
  end

  assign setup_active_o = state_q == SETUP_DATA;
  assign bulk_active_o = state_q == BULK_DATA;
  assign discard_o = state_q == SETUP_DATA || state_q == DUMP;
  assign ctl_start_o = start_q;
  assign setup_event_o = start_q;
  assign bulk_ack_event_o = bulk_event_q;

endmodule

// File: logic/usb_transaction_top.sv
module usb_transaction_top #(
  parameter int ENDPOINT1 = 1,
  parameter int ENDPOINT2 = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  // Token strobe from the packet decoder
  input  logic                   tok_recv_i,
  input  usb_txn_pkg::tok_type_t tok_type_i,
  input  usb_txn_pkg::usb_addr_t tok_addr_i,
  input  usb_txn_pkg::usb_endp_t tok_endp_i,
  // Received data packets
  input  logic                   out_tvalid_i,
  output logic                   out_tready_o,
  input  logic                   out_tlast_i,
  input  logic [1:0]             out_ttype_i,
  input  usb_txn_pkg::usb_byte_t out_tdata_i,
  // Handshake to the packet encoder
  output logic                   hsk_send_o,
  output usb_txn_pkg::hsk_type_t hsk_type_o,
  input  logic                   hsk_sent_i,
  // Setup request fields
  output logic                   ctl_start_o,
  output usb_txn_pkg::usb_byte_t ctl_rtype_o,
  output usb_txn_pkg::usb_byte_t ctl_request_o,
  output usb_txn_pkg::word16_t   ctl_value_o,
  output usb_txn_pkg::word16_t   ctl_index_o,
  output usb_txn_pkg::word16_t   ctl_length_o,
  // Bulk OUT stream
  output logic                   blk_ep_o,
  output logic                   blk_tvalid_o,
  input  logic                   blk_tready_i,
  output logic                   blk_tlast_o,
  output usb_txn_pkg::usb_byte_t blk_tdata_o,
  // Register bus
  input  usb_txn_pkg::axi_addr_t s_axi_awaddr_i,
  input  logic                   s_axi_awvalid_i,
  output logic                   s_axi_awready_o,
  input  usb_txn_pkg::axi_data_t s_axi_wdata_i,
  input  logic                   s_axi_wvalid_i,
  output logic                   s_axi_wready_o,
  output logic                   s_axi_bvalid_o,
  input  logic                   s_axi_bready_i,
  input  usb_txn_pkg::axi_addr_t s_axi_araddr_i,
  input  logic                   s_axi_arvalid_i,
  output logic                   s_axi_arready_o,
  output usb_txn_pkg::axi_data_t s_axi_rdata_o,
  output logic                   s_axi_rvalid_o,
  input  logic                   s_axi_rready_i
);
  import usb_txn_pkg::*;

  usb_addr_t dev_addr;
  logic [1:0] ep_enable;
  logic [1:0] ep_halt;
  logic setup_event;
  logic bulk_ack_event;
  logic setup_active;
  logic bulk_active;
  logic ep_sel;
  logic discard;
  logic setup_ok;
  hsk_type_t bulk_hsk_type;
  logic bulk_ack;
  logic hsk_req;
  hsk_type_t hsk_req_type;
  logic hsk_busy;

  usb_cfg_regs u_cfg_regs (
    .clock            (clock),
    .reset            (reset),
    .s_axi_awaddr_i   (s_axi_awaddr_i),
    .s_axi_awvalid_i  (s_axi_awvalid_i),
    .s_axi_awready_o  (s_axi_awready_o),
    .s_axi_wdata_i    (s_axi_wdata_i),
    .s_axi_wvalid_i   (s_axi_wvalid_i),
    .s_axi_wready_o   (s_axi_wready_o),
    .s_axi_bvalid_o   (s_axi_bvalid_o),
    .s_axi_bready_i   (s_axi_bready_i),
    .s_axi_araddr_i   (s_axi_araddr_i),
    .s_axi_arvalid_i  (s_axi_arvalid_i),
    .s_axi_arready_o  (s_axi_arready_o),
    .s_axi_rdata_o    (s_axi_rdata_o),
    .s_axi_rvalid_o   (s_axi_rvalid_o),
    .s_axi_rready_i   (s_axi_rready_i),
    .setup_event_i    (setup_event),
    .bulk_ack_event_i (bulk_ack_event),
    .dev_addr_o       (dev_addr),
    .ep_enable_o      (ep_enable),
    .ep_halt_o        (ep_halt)
  );

  transaction_fsm #(
    .ENDPOINT1 (ENDPOINT1),
    .ENDPOINT2 (ENDPOINT2)
  ) u_fsm (
    .clock            (clock),
    .reset            (reset),
    .tok_recv_i       (tok_recv_i),
    .tok_type_i       (tok_type_i),
    .tok_addr_i       (tok_addr_i),
    .tok_endp_i       (tok_endp_i),
    .dev_addr_i       (dev_addr),
    .ep_enable_i      (ep_enable),
    .out_tvalid_i     (out_tvalid_i),
    .out_tready_i     (out_tready_o),
    .out_tlast_i      (out_tlast_i),
    .setup_ok_i       (setup_ok),
    .bulk_hsk_type_i  (bulk_hsk_type),
    .bulk_ack_i       (bulk_ack),
    .hsk_busy_i       (hsk_busy),
    .setup_active_o   (setup_active),
    .bulk_active_o    (bulk_active),
    .ep_sel_o         (ep_sel),
    .discard_o        (discard),
    .ctl_start_o      (ctl_start_o),
    .hsk_req_o        (hsk_req),
    .hsk_req_type_o   (hsk_req_type),
    .setup_event_o    (setup_event),
    .bulk_ack_event_o (bulk_ack_event)
  );

  setup_parser u_setup (
    .clock          (clock),
    .reset          (reset),
    .setup_active_i (setup_active),
    .out_tvalid_i   (out_tvalid_i),
    .out_tready_i   (out_tready_o),
    .out_tlast_i    (out_tlast_i),
    .out_ttype_i    (out_ttype_i),
    .out_tdata_i    (out_tdata_i),
    .ctl_rtype_o    (ctl_rtype_o),
    .ctl_request_o  (ctl_request_o),
    .ctl_value_o    (ctl_value_o),
    .ctl_index_o    (ctl_index_o),
    .ctl_length_o   (ctl_length_o),
    .setup_ok_o     (setup_ok)
  );

  // Also drives out_tready_o, merging in the discard ready
  bulk_out_endpoint u_bulk (
    .clock           (clock),
    .reset           (reset),
    .bulk_active_i   (bulk_active),
    .discard_i       (discard),
    .ep_sel_i        (ep_sel),
    .ep_enable_i     (ep_enable),
    .ep_halt_i       (ep_halt),
    .out_tvalid_i    (out_tvalid_i),
    .out_tlast_i     (out_tlast_i),
    .out_ttype_i     (out_ttype_i),
    .out_tdata_i     (out_tdata_i),
    .blk_tready_i    (blk_tready_i),
    .out_tready_o    (out_tready_o),
    .blk_ep_o        (blk_ep_o),
    .blk_tvalid_o    (blk_tvalid_o),
    .blk_tlast_o     (blk_tlast_o),
    .blk_tdata_o     (blk_tdata_o),
    .bulk_hsk_type_o (bulk_hsk_type),
    .bulk_ack_o      (bulk_ack)
  );

  handshake_issuer u_hsk (
    .clock          (clock),
    .reset          (reset),
    .hsk_req_i      (hsk_req),
    .hsk_req_type_i (hsk_req_type),
    .hsk_sent_i     (hsk_sent_i),
    .hsk_send_o     (hsk_send_o),
    .hsk_type_o     (hsk_type_o),
    .hsk_busy_o     (hsk_busy)
  );

endmodule

// File: verification/tb_usb_tasks.svh
`ifndef TB_USB_TASKS_SVH
`define TB_USB_TASKS_SVH

// Error line, fail message, then stop
task automatic abort_run(input string line);
  $display("%s", line);
  $display("Test failed");
  $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    abort_run($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
  end
endtask

// AW and W together, then wait for the write response
task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
  int n;
  s_axi_awaddr_i = addr;
  s_axi_wdata_i = data;
  s_axi_awvalid_i = 1'b1;
  s_axi_wvalid_i = 1'b1;
  s_axi_bready_i = 1'b1;
  n = 0;
  @(negedge clock);
  while (!s_axi_awready_o) begin
    n++;
    if (n > 50) abort_run("Timeout: AXI write address and data were never accepted");
    @(negedge clock);
  end
  // Data channel is taken in the same cycle as the address
  check_value("s_axi_wready_o", 32'(s_axi_wready_o), 32'd1);
  @(posedge clock);
  #10;
  s_axi_awvalid_i = 1'b0;
  s_axi_wvalid_i = 1'b0;
  n = 0;
  @(negedge clock);
  while (!s_axi_bvalid_o) begin
    n++;
    if (n > 50) abort_run("Timeout: AXI write response never arrived");
    @(negedge clock);
  end
  @(posedge clock);
  #10;
  s_axi_bready_i = 1'b0;
endtask

task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
  int n;
  s_axi_araddr_i = addr;
  s_axi_arvalid_i = 1'b1;
  s_axi_rready_i = 1'b1;
  n = 0;
  @(negedge clock);
  while (!s_axi_arready_o) begin
    n++;
    if (n > 50) abort_run("Timeout: AXI read address was never accepted");
    @(negedge clock);
  end
  @(posedge clock);
  #10;
  s_axi_arvalid_i = 1'b0;
  n = 0;
  @(negedge clock);
  while (!s_axi_rvalid_o) begin
    n++;
    if (n > 50) abort_run("Timeout: AXI read data never arrived");
    @(negedge clock);
  end
  data = s_axi_rdata_o;
  @(posedge clock);
  #10;
  s_axi_rready_i = 1'b0;
endtask

// One-cycle token strobe
task automatic send_token(input tok_type_t t, input usb_addr_t a, input usb_endp_t e);
  tok_recv_i = 1'b1;
  tok_type_i = t;
  tok_addr_i = a;
  tok_endp_i = e;
  @(posedge clock);
  #10;
  tok_recv_i = 1'b0;
endtask

// Bytes come from pkt_bytes; the sink ready is random every cycle
task automatic send_packet(input logic pid, input int len);
  int n;
  for (int i = 0; i < len; i++) begin
    out_tvalid_i = 1'b1;
    out_tlast_i = (i == len - 1);
    out_tdata_i = pkt_bytes[i];
    out_ttype_i = {1'b0, pid};
    n = 0;
    @(negedge clock);
    while (!out_tready_o) begin
      n++;
      if (n > 100) abort_run("Timeout: the DUT never accepted a stream byte");
      @(posedge clock);
      #10;
      blk_tready_i = ($random(seed) & 3) != 0;
      @(negedge clock);
    end
    @(posedge clock);
    #10;
    blk_tready_i = ($random(seed) & 3) != 0;
  end
  out_tvalid_i = 1'b0;
  out_tlast_i = 1'b0;
endtask

// Setup fields are little endian over the eight bytes
task automatic check_setup_fields();
  check_value("ctl_rtype_o", 32'(ctl_rtype_o), 32'(pkt_bytes[0]));
  check_value("ctl_request_o", 32'(ctl_request_o), 32'(pkt_bytes[1]));
  check_value("ctl_value_o", 32'(ctl_value_o), {16'd0, pkt_bytes[3], pkt_bytes[2]});
  check_value("ctl_index_o", 32'(ctl_index_o), {16'd0, pkt_bytes[5], pkt_bytes[4]});
  check_value("ctl_length_o", 32'(ctl_length_o), {16'd0, pkt_bytes[7], pkt_bytes[6]});
endtask

// Waits for the request, then plays the encoder with a random delay
task automatic wait_handshake(input hsk_type_t exp_type, input logic is_setup);
  int n;
  int delay;
  n = 0;
  @(negedge clock);
  while (!hsk_send_o) begin
    n++;
    if (n > 20) abort_run("Timeout: no handshake was requested within 20 cycles");
    @(negedge clock);
  end
  check_value("hsk_type_o", 32'(hsk_type_o), 32'(exp_type));
  // Start strobe shares the first cycle of the request
  check_value("ctl_start_o", 32'(ctl_start_o), 32'(is_setup));
  if (is_setup) check_setup_fields();
  delay = 1 + ($unsigned($random(seed)) % 4);
  repeat (delay) @(posedge clock);
  #10;
  check_value("hsk_send_o while pending", 32'(hsk_send_o), 32'd1);
  check_value("hsk_type_o while pending", 32'(hsk_type_o), 32'(exp_type));
  hsk_sent_i = 1'b1;
  @(posedge clock);
  #10;
  hsk_sent_i = 1'b0;
  @(negedge clock);
  check_value("hsk_send_o after sent", 32'(hsk_send_o), 32'd0);
  @(posedge clock);
  #10;
endtask

// Neither a handshake nor a start strobe for some cycles
task automatic expect_silence(input int cycles);
  repeat (cycles) begin
    @(negedge clock);
    check_value("hsk_send_o on a silent transaction", 32'(hsk_send_o), 32'd0);
    check_value("ctl_start_o on a silent transaction", 32'(ctl_start_o), 32'd0);
  end
  @(posedge clock);
  #10;
endtask

`endif

// File: verification/tb_usb_transaction.sv
module tb_usb_transaction;
  import usb_txn_pkg::*;

  localparam int ENDPOINT1 = 1;
  localparam int ENDPOINT2 = 2;
  localparam usb_addr_t DEV_ADDR = 7'h2A;

  logic clock;
  logic reset;
  logic tok_recv_i;
  tok_type_t tok_type_i;
  usb_addr_t tok_addr_i;
  usb_endp_t tok_endp_i;
  logic out_tvalid_i;
  logic out_tready_o;
  logic out_tlast_i;
  logic [1:0] out_ttype_i;
  usb_byte_t out_tdata_i;
  logic hsk_send_o;
  hsk_type_t hsk_type_o;
  logic hsk_sent_i;
  logic ctl_start_o;
  usb_byte_t ctl_rtype_o;
  usb_byte_t ctl_request_o;
  word16_t ctl_value_o;
  word16_t ctl_index_o;
  word16_t ctl_length_o;
  logic blk_ep_o;
  logic blk_tvalid_o;
  logic blk_tready_i;
  logic blk_tlast_o;
  usb_byte_t blk_tdata_o;
  axi_addr_t s_axi_awaddr_i;
  logic s_axi_awvalid_i;
  logic s_axi_awready_o;
  axi_data_t s_axi_wdata_i;
  logic s_axi_wvalid_i;
  logic s_axi_wready_o;
  logic s_axi_bvalid_o;
  logic s_axi_bready_i;
  axi_addr_t s_axi_araddr_i;
  logic s_axi_arvalid_i;
  logic s_axi_arready_o;
  axi_data_t s_axi_rdata_o;
  logic s_axi_rvalid_o;
  logic s_axi_rready_i;

  integer seed;
  axi_data_t rd_data;
  // Reference model state
  logic [1:0] toggle_m;
  logic [1:0] enable_m;
  logic [1:0] halt_m;
  logic [7:0] setup_cnt_m;
  logic [7:0] bulk_cnt_m;
  usb_byte_t pkt_bytes [0:15];
  // Bytes seen on the bulk stream
  usb_byte_t rx_bytes[$];
  logic rx_ep[$];
  logic rx_last[$];

  usb_transaction_top #(
    .ENDPOINT1 (ENDPOINT1),
    .ENDPOINT2 (ENDPOINT2)
  ) i_dut (
    .clock (clock), .reset (reset),
    .tok_recv_i (tok_recv_i), .tok_type_i (tok_type_i),
    .tok_addr_i (tok_addr_i), .tok_endp_i (tok_endp_i),
    .out_tvalid_i (out_tvalid_i), .out_tready_o (out_tready_o),
    .out_tlast_i (out_tlast_i), .out_ttype_i (out_ttype_i), .out_tdata_i (out_tdata_i),
    .hsk_send_o (hsk_send_o), .hsk_type_o (hsk_type_o), .hsk_sent_i (hsk_sent_i),
    .ctl_start_o (ctl_start_o), .ctl_rtype_o (ctl_rtype_o), .ctl_request_o (ctl_request_o),
    .ctl_value_o (ctl_value_o), .ctl_index_o (ctl_index_o), .ctl_length_o (ctl_length_o),
    .blk_ep_o (blk_ep_o), .blk_tvalid_o (blk_tvalid_o), .blk_tready_i (blk_tready_i),
    .blk_tlast_o (blk_tlast_o), .blk_tdata_o (blk_tdata_o),
    .s_axi_awaddr_i (s_axi_awaddr_i), .s_axi_awvalid_i (s_axi_awvalid_i),
    .s_axi_awready_o (s_axi_awready_o), .s_axi_wdata_i (s_axi_wdata_i),
    .s_axi_wvalid_i (s_axi_wvalid_i), .s_axi_wready_o (s_axi_wready_o),
    .s_axi_bvalid_o (s_axi_bvalid_o), .s_axi_bready_i (s_axi_bready_i),
    .s_axi_araddr_i (s_axi_araddr_i), .s_axi_arvalid_i (s_axi_arvalid_i),
    .s_axi_arready_o (s_axi_arready_o), .s_axi_rdata_o (s_axi_rdata_o),
    .s_axi_rvalid_o (s_axi_rvalid_o), .s_axi_rready_i (s_axi_rready_i)
  );

  `include "tb_usb_tasks.svh"

  always #50 clock = ~clock;

  // Stream monitor, sampled mid-cycle
  always @(negedge clock) begin
    if (blk_tvalid_o && blk_tready_i) begin
      rx_bytes.push_back(blk_tdata_o);
      rx_ep.push_back(blk_ep_o);
      rx_last.push_back(blk_tlast_o);
    end
  end

  // Compares what the monitor saw with the packet in pkt_bytes
  task automatic check_stream(input int exp_len, input logic exp_ep);
    check_value("forwarded byte count", 32'(rx_bytes.size()), 32'(exp_len));
    for (int i = 0; i < exp_len; i++) begin
      check_value("blk_tdata_o", 32'(rx_bytes[i]), 32'(pkt_bytes[i]));
      check_value("blk_ep_o", 32'(rx_ep[i]), 32'(exp_ep));
      check_value("blk_tlast_o", 32'(rx_last[i]), 32'(i == exp_len - 1));
    end
    rx_bytes.delete();
    rx_ep.delete();
    rx_last.delete();
  endtask

  task automatic run_bulk_out(input int idx, input logic pid, input int len);
    send_token(TOK_OUT, DEV_ADDR, (idx == 1) ? usb_endp_t'(ENDPOINT2) : usb_endp_t'(ENDPOINT1));
    send_packet(pid, len);
    if (!enable_m[idx]) begin
      expect_silence(20);
      check_stream(0, 1'b0);
    end else if (halt_m[idx]) begin
      wait_handshake(HSK_STALL, 1'b0);
      check_stream(0, 1'b0);
    end else if (pid == toggle_m[idx]) begin
      wait_handshake(HSK_ACK, 1'b0);
      check_stream(len, idx[0]);
      toggle_m[idx] = ~toggle_m[idx];
      bulk_cnt_m = bulk_cnt_m + 8'd1;
    end else begin
      // Duplicate packet, acknowledged and dropped
      wait_handshake(HSK_ACK, 1'b0);
      check_stream(0, 1'b0);
    end
  endtask

  task automatic run_transaction();
    int kind;
    int len;
    int idx;
    usb_endp_t endp;
    kind = $unsigned($random(seed)) % 8;
    idx = $unsigned($random(seed)) % 2;
    len = 1 + ($unsigned($random(seed)) % 16);
    for (int i = 0; i < 16; i++) pkt_bytes[i] = 8'($random(seed));
    case (kind)
      0, 1: begin
        send_token(TOK_SETUP, DEV_ADDR, 4'd0);
        send_packet(1'b0, 8);
        wait_handshake(HSK_ACK, 1'b1);
        setup_cnt_m = setup_cnt_m + 8'd1;
        check_stream(0, 1'b0);
      end
      2: begin
        // Setup length 1 to 7 or 9 to 16
        if (len == 8) len = 16;
        send_token(TOK_SETUP, DEV_ADDR, 4'd0);
        send_packet(1'b0, len);
        expect_silence(20);
        check_stream(0, 1'b0);
      end
      3, 4: run_bulk_out(idx, toggle_m[idx], len);
      5: run_bulk_out(idx, ~toggle_m[idx], len);
      6: begin
        send_token(TOK_IN, DEV_ADDR, (idx == 1) ? usb_endp_t'(ENDPOINT2) : usb_endp_t'(ENDPOINT1));
        if (enable_m[idx]) wait_handshake(HSK_NAK, 1'b0);
        else expect_silence(20);
      end
      default: begin
        // Other address, or an endpoint that is not ours
        if (idx == 0) begin
          send_token(TOK_OUT, DEV_ADDR ^ usb_addr_t'(1 + ($unsigned($random(seed)) % 127)), 4'd1);
        end else begin
          do endp = 4'($random(seed));
          while (endp == usb_endp_t'(ENDPOINT1) || endp == usb_endp_t'(ENDPOINT2));
          send_token(TOK_OUT, DEV_ADDR, endp);
        end
        send_packet(1'($random(seed)), len);
        expect_silence(20);
        check_stream(0, 1'b0);
      end
    endcase
  endtask

  initial begin
    seed = 55;
    clock = 1'b0;
    reset = 1'b1;
    tok_recv_i = 1'b0;
    tok_type_i = TOK_OUT;
    tok_addr_i = '0;
    tok_endp_i = '0;
    out_tvalid_i = 1'b0;
    out_tlast_i = 1'b0;
    out_ttype_i = 2'b00;
    out_tdata_i = '0;
    hsk_sent_i = 1'b0;
    blk_tready_i = 1'b0;
    s_axi_awaddr_i = '0;
    s_axi_awvalid_i = 1'b0;
    s_axi_wdata_i = '0;
    s_axi_wvalid_i = 1'b0;
    s_axi_bready_i = 1'b0;
    s_axi_araddr_i = '0;
    s_axi_arvalid_i = 1'b0;
    s_axi_rready_i = 1'b0;
    toggle_m = 2'b00;
    setup_cnt_m = 8'd0;
    bulk_cnt_m = 8'd0;
    repeat (5) @(posedge clock);
    #10;
    reset = 1'b0;
    axi_write(REG_ADDR, 32'(DEV_ADDR));
    axi_write(REG_EPCTL, 32'h03);
    enable_m = 2'b11;
    halt_m = 2'b00;
    for (int t = 0; t < 300; t++) begin
      if (t == 100) begin
        // Halt the first bulk endpoint
        axi_write(REG_EPCTL, 32'h13);
        halt_m = 2'b01;
      end
      if (t == 200) begin
        // Release the halt and disable the second endpoint
        axi_write(REG_EPCTL, 32'h01);
        halt_m = 2'b00;
        enable_m = 2'b01;
        toggle_m[1] = 1'b0;
      end
      run_transaction();
    end
    axi_read(REG_STAT, rd_data);
    check_value("REG_STAT", rd_data, {16'd0, bulk_cnt_m, setup_cnt_m});
    axi_read(REG_ADDR, rd_data);
    check_value("REG_ADDR", rd_data, 32'(DEV_ADDR));
    axi_read(REG_EPCTL, rd_data);
    check_value("REG_EPCTL", rd_data, 32'h01);
    // A write to the status register clears both counters
    axi_write(REG_STAT, 32'h0);
    axi_read(REG_STAT, rd_data);
    check_value("REG_STAT after clear", rd_data, 32'h0);
    $display("Test passed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+verification
logic/usb_txn_pkg.sv
logic/usb_cfg_regs.sv
logic/setup_parser.sv
logic/bulk_out_endpoint.sv
logic/handshake_issuer.sv
logic/transaction_fsm.sv
logic/usb_transaction_top.sv
verification/tb_usb_transaction.sv

// File: Makefile
# Verilator build for the USB transaction layer

VERILATOR  ?= verilator
TOP        := tb_usb_transaction
RTL_TOP    := usb_transaction_top
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --Mdir $(OBJ_DIR)
PASS_MSG   := Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)
